/* Makefile */
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tbExeStage
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FLIST))
HEADERS := riscv_cfg.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

/* alu.sv */
// ==========================================================
// RV32I integer ALU
// ==========================================================

`timescale 1ns/1ps

`include "riscv_cfg.svh"

module alu import riscvPkg::*; (
    input  logic [`XLEN-1:0] opA,
    input  logic [`XLEN-1:0] opB,
    input  aluOp_e           aluOp,
    output logic [`XLEN-1:0] result
);

    // Shift amount from the low bits of B
    logic [4:0] shamt;

    // Signed views for compare and SRA
    logic signed [`XLEN-1:0] opASigned;
    logic signed [`XLEN-1:0] opBSigned;

    assign shamt     = opB[4:0];
    assign opASigned = opA;
    assign opBSigned = opB;

    always_comb begin
        // Unused encodings give zero
        result = '0;
        case (aluOp)
            ADD: begin
                result = opA + opB;
            end
            SUB: begin
                result = opA - opB;
            end
            SLL: begin
                result = opA << shamt;
            end
            SLT: begin
                // Set on signed less than
                result = {{(`XLEN-1){1'b0}}, (opASigned < opBSigned)};
            end
            SLTU: begin
                result = {{(`XLEN-1){1'b0}}, (opA < opB)};
            end
            XOR: begin
                result = opA ^ opB;
            end
            SRL: begin
                result = opA >> shamt;
            end
            SRA: begin
                // Sign bit fills from the top
                result = opASigned >>> shamt;
            end
            OR: begin
                result = opA | opB;
            end
            AND: begin
                result = opA & opB;
            end
            PASSB: begin
                // LUI, immediate already shifted by decode
                result = opB;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* exe.sv */
// ==========================================================
// Execute block, operand muxes and ALU
// ==========================================================

`timescale 1ns/1ps

`include "riscv_cfg.svh"

module exe import riscvPkg::*; (
    input  aluOp_e           aluOp,
    input  srcA_e            srcA,
    input  srcB_e            srcB,
    input  fwdSel_e          fwdA,
    input  fwdSel_e          fwdB,
    // Forwarding values from the stage registers
    input  logic [`XLEN-1:0] fwdAluData,
    input  logic [`XLEN-1:0] fwdWbData,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] imm,
    input  logic [`XLEN-1:0] rs1Data,
    input  logic [`XLEN-1:0] rs2Data,
    output logic [`XLEN-1:0] aluResult,
    output logic [`XLEN-1:0] storeData
);

    // First level outputs, register operands after forwarding
    logic [`XLEN-1:0] rs1Fwd;
    logic [`XLEN-1:0] rs2Fwd;

    // Second level outputs, ALU operands
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;

    // First level, forwarding
    always_comb begin
        case (fwdA)
            fwdAlu:  rs1Fwd = fwdAluData;
            fwdWb:   rs1Fwd = fwdWbData;
            default: rs1Fwd = rs1Data;
        endcase

        case (fwdB)
            fwdAlu:  rs2Fwd = fwdAluData;
            fwdWb:   rs2Fwd = fwdWbData;
            default: rs2Fwd = rs2Data;
        endcase
    end

    // Second level, pc or immediate in place of registers
    always_comb begin
        opA = (srcA == srcPc) ? pc : rs1Fwd;
        opB = (srcB == srcImm) ? imm : rs2Fwd;
    end

    // Stores take the forwarded rs2 even when B is the immediate
    assign storeData = rs2Fwd;

    alu alu_i (
        .opA    (opA),
        .opB    (opB),
        .aluOp  (aluOp),
        .result (aluResult)
    );

    // Unknown selects would pick a wrong operand silently
    always_comb begin
        assert final (!$isunknown({fwdA, fwdB, srcA, srcB}))
            else $error("exe: operand select is unknown");
    end

endmodule

/* exeStage.sv */
// ==========================================================
// Execute stage with forwarding and two stage registers
// ==========================================================

`timescale 1ns/1ps

`include "riscv_cfg.svh"

module exeStage import riscvPkg::*; (
    input  logic                   CLK,
    input  logic                   rst,
    // Decoded instruction entering execute
    input  logic                   inValid,
    input  aluOp_e                 aluOp,
    input  srcA_e                  srcA,
    input  srcB_e                  srcB,
    input  logic [`REG_ADDR_W-1:0] rs1Addr,
    input  logic [`REG_ADDR_W-1:0] rs2Addr,
    input  logic [`REG_ADDR_W-1:0] rdAddr,
    input  logic                   regWrite,
    input  logic [`XLEN-1:0]       pc,
    input  logic [`XLEN-1:0]       imm,
    // Register file read data, without the two in-flight results
    input  logic [`XLEN-1:0]       rs1Data,
    input  logic [`XLEN-1:0]       rs2Data,
    // Writeback side
    output logic                   wbValid,
    output logic [`REG_ADDR_W-1:0] wbRd,
    output logic                   wbRegWrite,
    output logic [`XLEN-1:0]       wbResult,
    output logic [`XLEN-1:0]       wbStoreData
);

    // Forwarding selects
    fwdSel_e fwdA;
    fwdSel_e fwdB;

    // Execute outputs
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] storeData;

    // EX/MEM register outputs
    logic                   exMemValid;
    logic [`REG_ADDR_W-1:0] exMemRd;
    logic                   exMemRegWrite;
    logic [`XLEN-1:0]       exMemResult;
    logic [`XLEN-1:0]       exMemStoreData;

    forwardUnit forwardUnit_i (
        .CLK           (CLK),
        .rs1Addr       (rs1Addr),
        .rs2Addr       (rs2Addr),
        .exMemValid    (exMemValid),
        .exMemRegWrite (exMemRegWrite),
        .exMemRd       (exMemRd),
        .memWbValid    (wbValid),
        .memWbRegWrite (wbRegWrite),
        .memWbRd       (wbRd),
        .fwdA          (fwdA),
        .fwdB          (fwdB)
    );

    // Forward paths come straight from the stage register outputs
    exe exe_i (
        .aluOp      (aluOp),
        .srcA       (srcA),
        .srcB       (srcB),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .fwdAluData (exMemResult),
        .fwdWbData  (wbResult),
        .pc         (pc),
        .imm        (imm),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .aluResult  (aluResult),
        .storeData  (storeData)
    );

    pipeReg exMemReg (
        .CLK          (CLK),
        .rst          (rst),
        .inValid      (inValid),
        .inRd         (rdAddr),
        .inRegWrite   (regWrite),
        .inResult     (aluResult),
        .inStoreData  (storeData),
        .outValid     (exMemValid),
        .outRd        (exMemRd),
        .outRegWrite  (exMemRegWrite),
        .outResult    (exMemResult),
        .outStoreData (exMemStoreData)
    );

    // Memory stage is a plain one cycle delay
    pipeReg memWbReg (
        .CLK          (CLK),
        .rst          (rst),
        .inValid      (exMemValid),
        .inRd         (exMemRd),
        .inRegWrite   (exMemRegWrite),
        .inResult     (exMemResult),
        .inStoreData  (exMemStoreData),
        .outValid     (wbValid),
        .outRd        (wbRd),
        .outRegWrite  (wbRegWrite),
        .outResult    (wbResult),
        .outStoreData (wbStoreData)
    );

endmodule

/* forwardUnit.sv */
// ==========================================================
// Forwarding unit
// ==========================================================

`timescale 1ns/1ps

`include "riscv_cfg.svh"

module forwardUnit import riscvPkg::*; (
    input  logic                   CLK,
    input  logic [`REG_ADDR_W-1:0] rs1Addr,
    input  logic [`REG_ADDR_W-1:0] rs2Addr,
    // Instruction one ahead, in EX/MEM
    input  logic                   exMemValid,
    input  logic                   exMemRegWrite,
    input  logic [`REG_ADDR_W-1:0] exMemRd,
    // Instruction two ahead, in MEM/WB
    input  logic                   memWbValid,
    input  logic                   memWbRegWrite,
    input  logic [`REG_ADDR_W-1:0] memWbRd,
    output fwdSel_e                fwdA,
    output fwdSel_e                fwdB
);

    // Stage will write a real register
    logic exMemWrites;
    logic memWbWrites;

    assign exMemWrites = exMemValid && exMemRegWrite && (exMemRd != '0);
    assign memWbWrites = memWbValid && memWbRegWrite && (memWbRd != '0);

    always_comb begin
        // Newest producer wins when both match
        if (exMemWrites && (exMemRd == rs1Addr)) begin
            fwdA = fwdAlu;
        end else if (memWbWrites && (memWbRd == rs1Addr)) begin
            fwdA = fwdWb;
        end else begin
            fwdA = fwdNone;
        end

        // Same rule for rs2
        if (exMemWrites && (exMemRd == rs2Addr)) begin
            fwdB = fwdAlu;
        end else if (memWbWrites && (memWbRd == rs2Addr)) begin
            fwdB = fwdWb;
        end else begin
            fwdB = fwdNone;
        end
    end

    // x0 never comes from a stage register
    assert property (@(posedge CLK)
        ((fwdA == fwdAlu) || (fwdB == fwdAlu)) |-> (exMemRd != '0))
        else $error("forwardUnit: EX/MEM selected with rd x0");

    assert property (@(posedge CLK)
        ((fwdA == fwdWb) || (fwdB == fwdWb)) |-> (memWbRd != '0))
        else $error("forwardUnit: MEM/WB selected with rd x0");

endmodule

/* pipeReg.sv */
// ==========================================================
// Pipeline stage register
// ==========================================================

`timescale 1ns/1ps

`include "riscv_cfg.svh"

module pipeReg (
    input  logic                   CLK,
    input  logic                   rst,
    input  logic                   inValid,
    input  logic [`REG_ADDR_W-1:0] inRd,
    input  logic                   inRegWrite,
    input  logic [`XLEN-1:0]       inResult,
    input  logic [`XLEN-1:0]       inStoreData,
    output logic                   outValid,
    output logic [`REG_ADDR_W-1:0] outRd,
    output logic                   outRegWrite,
    output logic [`XLEN-1:0]       outResult,
    output logic [`XLEN-1:0]       outStoreData
);

    // Control bits, cleared so nothing writes back after reset
    always_ff @(posedge CLK) begin
        if (rst) begin
            outValid    <= 1'b0;
            outRegWrite <= 1'b0;
        end else begin
            // Bubbles move on like any item
            outValid    <= inValid;
            outRegWrite <= inRegWrite;
        end
    end

    // Payload, qualified by outValid downstream
    always_ff @(posedge CLK) begin
        outRd        <= inRd;
        outResult    <= inResult;
        outStoreData <= inStoreData;
    end

    // Stage empty right after reset
    assert property (@(posedge CLK) rst |=> (!outValid && !outRegWrite))
        else $error("pipeReg: stage not empty after reset");

endmodule

/* riscvPkg.sv */
// ==========================================================
// RV32I execute types
// ==========================================================

package riscvPkg;

    // ALU operation, set by decode
    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        SLL   = 4'd2,
        // Signed compare
        SLT   = 4'd3,
        // Unsigned compare
        SLTU  = 4'd4,
        XOR   = 4'd5,
        SRL   = 4'd6,
        // Arithmetic right shift
        SRA   = 4'd7,
        OR    = 4'd8,
        AND   = 4'd9,
        // Operand B straight through, for LUI
        PASSB = 4'd10
    } aluOp_e;

    // Forwarding source for one register operand
    typedef enum logic [1:0] {
        // Register file value
        fwdNone = 2'd0,
        // Result held in the EX/MEM register
        fwdAlu  = 2'd1,
        // Result held in the MEM/WB register
        fwdWb   = 2'd2
    } fwdSel_e;

    // Second level select for operand A
    typedef enum logic {
        srcRs1 = 1'b0,
        srcPc  = 1'b1
    } srcA_e;

    // Second level select for operand B
    typedef enum logic {
        srcRs2 = 1'b0,
        srcImm = 1'b1
    } srcB_e;

endpackage

/* riscv_cfg.svh */
// ==========================================================
// RV32I datapath sizes
// ==========================================================

`ifndef RISCV_CFG_SVH
`define RISCV_CFG_SVH

// Integer register and datapath width
`define XLEN 32

// Register file address width, x0 to x31
`define REG_ADDR_W 5

`endif

/* tbExeStage.sv */
// ==========================================================
// Execute stage testbench
// ==========================================================

`timescale 1ns/1ps

`include "riscv_cfg.svh"

module tbExeStage import riscvPkg::*;;

    localparam int NUM_RANDOM     = 300;
    // Random run plus directed cases, reset and drain
    localparam int TIMEOUT_CYCLES = NUM_RANDOM + 100;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // One expected writeback item including bubbles
    typedef struct packed {
        int                     due;
        logic                   valid;
        logic                   regWrite;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       result;
        logic [`XLEN-1:0]       store;
    } expItem_t;

    logic                   CLK;
    logic                   rst;
    logic                   inValid;
    aluOp_e                 aluOp;
    srcA_e                  srcA;
    srcB_e                  srcB;
    logic [`REG_ADDR_W-1:0] rs1Addr;
    logic [`REG_ADDR_W-1:0] rs2Addr;
    logic [`REG_ADDR_W-1:0] rdAddr;
    logic                   regWrite;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       rs1Data;
    logic [`XLEN-1:0]       rs2Data;
    logic                   wbValid;
    logic [`REG_ADDR_W-1:0] wbRd;
    logic                   wbRegWrite;
    logic [`XLEN-1:0]       wbResult;
    logic [`XLEN-1:0]       wbStoreData;

    // Register file seen by execute lags two instructions
    logic [`XLEN-1:0] rfModel [2**`REG_ADDR_W];
    // Architectural state updated at issue
    logic [`XLEN-1:0] archRegs [2**`REG_ADDR_W];
    expItem_t         expQ [$];
    logic [31:0]      lfsr = 32'd33;
    int               cycle = 0;

    exeStage exeStage_i (
        .CLK(CLK), .rst(rst), .inValid(inValid), .aluOp(aluOp), .srcA(srcA), .srcB(srcB),
        .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rdAddr(rdAddr), .regWrite(regWrite),
        .pc(pc), .imm(imm), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .wbValid(wbValid), .wbRd(wbRd), .wbRegWrite(wbRegWrite),
        .wbResult(wbResult), .wbStoreData(wbStoreData)
    );

    always #20 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle <= cycle + 1;
    end

    // Expected result from the RV32I rules
    function automatic logic [31:0] refResult(aluOp_e op, srcA_e sa, srcB_e sb,
            logic [31:0] rs1Val, logic [31:0] rs2Val, logic [31:0] pcVal, logic [31:0] immVal);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        a  = (sa == srcPc) ? pcVal : rs1Val;
        b  = (sb == srcImm) ? immVal : rs2Val;
        sh = b[4:0];
        case (op)
            ADD:   return a + b;
            SUB:   return a + ~b + 32'd1;
            SLL:   return a << sh;
            // With differing signs the negative one is smaller
            SLT:   return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            SLTU:  return {31'd0, a < b};
            XOR:   return a ^ b;
            SRL:   return a >> sh;
            SRA:   return (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0);
            OR:    return a | b;
            AND:   return a & b;
            PASSB: return b;
            default: return 32'd0;
        endcase
    endfunction

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] randBits(int n);
        logic [31:0] value;
        logic        outBit;
        value = '0;
        for (int i = 0; i < n; i++) begin
            outBit = lfsr[0];
            lfsr   = (lfsr >> 1) ^ (outBit ? LFSR_TAPS : 32'd0);
            value  = {value[30:0], outBit};
        end
        return value;
    endfunction

    task automatic compareValue(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s = %h, expected %h", $time, name, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    // Drive one slot and record what must come out two cycles later
    task automatic issueInstr(logic valid, aluOp_e op, srcA_e sa, srcB_e sb,
            logic [4:0] rs1, logic [4:0] rs2, logic [4:0] rd, logic we,
            logic [31:0] pcVal, logic [31:0] immVal);
        expItem_t item;
        @(posedge CLK);
        #1;
        inValid  = valid;
        aluOp    = op;
        srcA     = sa;
        srcB     = sb;
        rs1Addr  = rs1;
        rs2Addr  = rs2;
        rdAddr   = rd;
        regWrite = we;
        pc       = pcVal;
        imm      = immVal;
        rs1Data  = rfModel[rs1];
        rs2Data  = rfModel[rs2];
        item.due      = cycle + 2;
        item.valid    = valid;
        item.regWrite = we;
        item.rd       = rd;
        item.result   = refResult(op, sa, sb, archRegs[rs1], archRegs[rs2], pcVal, immVal);
        item.store    = archRegs[rs2];
        expQ.push_back(item);
        if (valid && we && (rd != 5'd0)) begin
            archRegs[rd] = item.result;
        end
    endtask

    // Bubble carrying a live looking write that must not forward
    task automatic issueBubble(logic [4:0] rd);
        issueInstr(1'b0, ADD, srcRs1, srcImm, 5'd1, 5'd1, rd, 1'b1, 32'd0, 32'hDEAD_BEEF);
    endtask

    // Register file write at writeback
    always @(negedge CLK) begin
        if (!rst && wbValid && wbRegWrite && (wbRd != '0)) begin
            rfModel[wbRd] <= wbResult;
        end
    end

    // Writeback compare with outputs settled since the rising edge
    always @(negedge CLK) begin
        expItem_t item;
        if (!rst) begin
            if ((expQ.size() > 0) && (expQ[0].due == cycle)) begin
                item = expQ.pop_front();
                compareValue("wbValid", 32'(wbValid), 32'(item.valid));
                if (item.valid) begin
                    compareValue("wbRd", 32'(wbRd), 32'(item.rd));
                    compareValue("wbRegWrite", 32'(wbRegWrite), 32'(item.regWrite));
                    compareValue("wbResult", wbResult, item.result);
                    compareValue("wbStoreData", wbStoreData, item.store);
                end
            end else if (wbValid) begin
                $display("Error at %0d ns: valid writeback with no instruction due", $time);
                $display("FAIL: see errors above");
                $fatal(1, "unexpected writeback");
            end
        end
    end

    always @(posedge CLK) begin
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0] opBits;
        CLK      = 1'b0;
        rst      = 1'b1;
        inValid  = 1'b0;
        aluOp    = ADD;
        srcA     = srcRs1;
        srcB     = srcRs2;
        rs1Addr  = '0;
        rs2Addr  = '0;
        rdAddr   = '0;
        regWrite = 1'b0;
        pc       = '0;
        imm      = '0;
        rs1Data  = '0;
        rs2Data  = '0;
        for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
            rfModel[i]  = '0;
            archRegs[i] = '0;
        end
        repeat (2) @(posedge CLK);
        #1;
        rst = 1'b0;

        // Only bubbles after reset
        repeat (4) issueBubble(5'd1);

        // Load x1 to x3 back to back
        issueInstr(1, PASSB, srcRs1, srcImm, 5'd0, 5'd0, 5'd1, 1, 32'h100, 32'h1234_5678);
        issueInstr(1, PASSB, srcRs1, srcImm, 5'd0, 5'd0, 5'd2, 1, 32'h104, 32'h8000_0F0F);
        issueInstr(1, PASSB, srcRs1, srcImm, 5'd0, 5'd0, 5'd3, 1, 32'h108, 32'hFFFF_FFF3);
        issueBubble(5'd2);
        issueBubble(5'd3);

        // Every opcode on settled registers with results to x0
        for (int i = 0; i <= 10; i++) begin
            issueInstr(1, aluOp_e'(i[3:0]), srcRs1, srcRs2, 5'd1, 5'd2, 5'd0, 1,
                       32'h200, 32'd0);
            issueInstr(1, aluOp_e'(i[3:0]), srcPc, srcImm, 5'd3, 5'd3, 5'd0, 1,
                       32'h8000_0200, 32'hFFFF_F000 | i);
            issueInstr(1, aluOp_e'(i[3:0]), srcRs1, srcImm, 5'd3, 5'd1, 5'd0, 0,
                       32'h208, 32'h0000_0003 + i);
        end

        // Distance one dependencies
        issueInstr(1, ADD, srcRs1, srcRs2, 5'd1, 5'd2, 5'd1, 1, 32'h300, 32'd0);
        issueInstr(1, SUB, srcRs1, srcRs2, 5'd1, 5'd3, 5'd2, 1, 32'h304, 32'd0);
        issueInstr(1, XOR, srcRs1, srcRs2, 5'd2, 5'd1, 5'd3, 1, 32'h308, 32'd0);
        // Distance two over a bubble
        issueInstr(1, ADD, srcRs1, srcImm, 5'd1, 5'd0, 5'd3, 1, 32'h30C, 32'h55);
        issueBubble(5'd3);
        issueInstr(1, OR, srcRs1, srcRs2, 5'd3, 5'd0, 5'd2, 1, 32'h310, 32'd0);
        // Same register twice where the younger must win
        issueInstr(1, PASSB, srcRs1, srcImm, 5'd0, 5'd0, 5'd1, 1, 32'h314, 32'hAAAA_0001);
        issueInstr(1, PASSB, srcRs1, srcImm, 5'd0, 5'd0, 5'd1, 1, 32'h318, 32'hBBBB_0002);
        issueInstr(1, ADD, srcRs1, srcRs2, 5'd1, 5'd1, 5'd2, 1, 32'h31C, 32'd0);
        // x0 destination then a read of x0 with forwarded store data
        issueInstr(1, PASSB, srcRs1, srcImm, 5'd0, 5'd0, 5'd0, 1, 32'h320, 32'h7777_7777);
        issueInstr(1, ADD, srcRs1, srcImm, 5'd0, 5'd2, 5'd3, 1, 32'h324, 32'h10);

        // Random run over registers x0 to x3
        for (int n = 0; n < NUM_RANDOM; n++) begin
            opBits = randBits(4) % 11;
            issueInstr(randBits(3) != 0, aluOp_e'(opBits[3:0]), srcA_e'(randBits(1) != 0),
                       srcB_e'(randBits(1) != 0), randBits(2), randBits(2), randBits(2),
                       randBits(2) != 0, randBits(32) & 32'hFFFF_FFFC, randBits(32));
        end

        @(posedge CLK);
        #1;
        inValid = 1'b0;
        while (expQ.size() != 0) begin
            @(posedge CLK);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
riscvPkg.sv
alu.sv
exe.sv
forwardUnit.sv
pipeReg.sv
exeStage.sv
tbExeStage.sv
